//--- design/kdi_pkg.sv
package kdi_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  // Digest block and entropy word are both 64 bit
  localparam int BlockWidth     = 64;
  localparam int KeyWidth       = 128;
  localparam int SeedWidth      = 256;
  localparam int EdnWidth       = 64;
  // Nonce is held as two entropy words
  localparam int NumNonceChunks = 2;
  // Flash data, flash address, SRAM, OTBN
  localparam int NumReq         = 4;

  typedef logic [BlockWidth-1:0]              block_t;
  typedef logic [KeyWidth-1:0]                key_t;
  typedef logic [SeedWidth-1:0]               seed_t;
  typedef logic [NumNonceChunks*EdnWidth-1:0] nonce_t;
  typedef logic [$clog2(NumReq)-1:0]          req_idx_t;
  // Counts seed blocks (0..3) and entropy words (0..1)
  typedef logic [1:0]                         chunk_cnt_t;

  // Digest constant selector
  typedef enum logic [1:0] {
    FlashDataKey,
    FlashAddrKey,
    SramDataKey
  } digest_sel_e;

  // Digest engine commands
  typedef enum logic [1:0] {
    LoadShadow,
    Digest,
    DigestInit,
    DigestFinalize
  } scrmbl_cmd_e;

  // Control FSM states
  typedef enum logic [3:0] {
    ResetSt,
    IdleSt,
    DigClrSt,
    DigLoadSt,
    FetchEntropySt,
    DigEntropySt,
    DigFinSt,
    DigWaitSt,
    FetchNonceSt,
    FinishSt,
    ErrorSt
  } kdi_state_e;

  //////////////////////////////////////////////////////////////////////
  // Per-requester configuration
  //////////////////////////////////////////////////////////////////////

  // Requesters with their own seed inputs
  localparam req_idx_t ReqIdxFlashData = 2'd0;
  localparam req_idx_t ReqIdxFlashAddr = 2'd1;

  // SRAM and OTBN mix entropy into the key
  localparam logic [NumReq-1:0] ReqIngestEntropy = 4'b1100;

  localparam digest_sel_e ReqDigestSel [NumReq] = '{
    FlashDataKey, FlashAddrKey, SramDataKey, SramDataKey
  };

  // Index of the last nonce chunk to fetch
  localparam chunk_cnt_t ReqNonceLast [NumReq] = '{2'd1, 2'd0, 2'd1, 2'd0};

endpackage

//--- design/kdi_req_arbiter.sv
`timescale 1ns/1ps

module kdi_req_arbiter (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // Requester side
  input  logic [kdi_pkg::NumReq-1:0]    key_req_i,
  output logic [kdi_pkg::NumReq-1:0]    key_ack_o,
  // Seeds from the OTP partitions
  input  kdi_pkg::seed_t                flash_data_seed_i,
  input  kdi_pkg::seed_t                flash_addr_seed_i,
  input  kdi_pkg::key_t                 sram_seed_i,
  input  logic                          seed_valid_i,
  // Request bundle towards the FSM
  output logic                          req_valid_o,
  input  logic                          req_ready_i,
  output logic                          ingest_entropy_o,
  output kdi_pkg::digest_sel_e          digest_sel_o,
  output kdi_pkg::chunk_cnt_t           nonce_last_o,
  output kdi_pkg::seed_t                seed_o,
  output logic                          seed_valid_o
);

  // Round-robin search start
  kdi_pkg::req_idx_t rr_ptr_q;
  // Grant held while the FSM works on it
  logic              lock_q;
  kdi_pkg::req_idx_t gnt_idx_q;

  logic              found;
  kdi_pkg::req_idx_t pick;
  kdi_pkg::req_idx_t grant_idx;

  //////////////////////////////////////////////////////////////////////
  // Round-robin search
  //////////////////////////////////////////////////////////////////////

  always_comb begin : p_search
    kdi_pkg::req_idx_t cand;
    found = 1'b0;
    pick  = rr_ptr_q;
    cand  = rr_ptr_q;
    // First raised request at or after the pointer, with wrap
    for (int i = 0; i < kdi_pkg::NumReq; i++) begin
      cand = rr_ptr_q + kdi_pkg::req_idx_t'(i);
      if (!found && key_req_i[cand]) begin
        found = 1'b1;
        pick  = cand;
      end
    end
  end

  // Locked choice wins over a fresh search
  assign grant_idx   = lock_q ? gnt_idx_q : pick;
  assign req_valid_o = lock_q | found;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_ptr_q  <= '0;
      lock_q    <= 1'b0;
      gnt_idx_q <= '0;
    end else if (req_ready_i) begin
      // Done, next search starts just past the served requester
      lock_q   <= 1'b0;
      rr_ptr_q <= grant_idx + kdi_pkg::req_idx_t'(1);
    end else if (req_valid_o && !lock_q) begin
      lock_q    <= 1'b1;
      gnt_idx_q <= pick;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Bundle and ack
  //////////////////////////////////////////////////////////////////////

  assign ingest_entropy_o = kdi_pkg::ReqIngestEntropy[grant_idx];
  assign digest_sel_o     = kdi_pkg::ReqDigestSel[grant_idx];
  assign nonce_last_o     = kdi_pkg::ReqNonceLast[grant_idx];
  assign seed_valid_o     = seed_valid_i;

  // SRAM and OTBN share the 128 bit seed, used twice
  always_comb begin
    case (grant_idx)
      kdi_pkg::ReqIdxFlashData: seed_o = flash_data_seed_i;
      kdi_pkg::ReqIdxFlashAddr: seed_o = flash_addr_seed_i;
      default:                  seed_o = {sram_seed_i, sram_seed_i};
    endcase
  end

  // One-cycle ack to the served requester
  always_comb begin
    key_ack_o = '0;
    if (req_ready_i) begin
      key_ack_o[grant_idx] = 1'b1;
    end
  end

endmodule

//--- design/kdi_ctrl_fsm.sv
`timescale 1ns/1ps

module kdi_ctrl_fsm (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  kdi_en_i,
  input  logic                  escalate_i,
  // Request bundle from the arbiter
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  input  logic                  ingest_entropy_i,
  input  kdi_pkg::digest_sel_e  digest_sel_i,
  input  kdi_pkg::chunk_cnt_t   nonce_last_i,
  output logic                  fsm_err_o,
  // Digest engine
  output logic                  scrmbl_valid_o,
  output kdi_pkg::scrmbl_cmd_e  scrmbl_cmd_o,
  output kdi_pkg::digest_sel_e  scrmbl_sel_o,
  input  logic                  scrmbl_ready_i,
  input  logic                  scrmbl_valid_i,
  // Entropy source
  output logic                  edn_req_o,
  input  logic                  edn_ack_i,
  // Datapath control
  output logic                  entropy_sel_o,
  output kdi_pkg::chunk_cnt_t   seed_cnt_o,
  output kdi_pkg::chunk_cnt_t   entropy_cnt_o,
  output logic                  key_we_o,
  output logic                  nonce_we_o,
  output logic                  seed_valid_we_o
);

  kdi_pkg::kdi_state_e state_d, state_q;
  kdi_pkg::chunk_cnt_t seed_cnt_q, entropy_cnt_q;
  logic seed_cnt_en, seed_cnt_clr;
  logic entropy_cnt_en, entropy_cnt_clr;
  logic edn_req_d, edn_req_q;
  logic edn_done;

  assign edn_req_o     = edn_req_q;
  assign seed_cnt_o    = seed_cnt_q;
  assign entropy_cnt_o = entropy_cnt_q;
  assign scrmbl_sel_o  = digest_sel_i;

  // Word arrives only against an open request
  assign edn_done = edn_req_q & edn_ack_i;

  //////////////////////////////////////////////////////////////////////
  // Next state logic
  //////////////////////////////////////////////////////////////////////

  always_comb begin : p_fsm
    state_d         = state_q;
    fsm_err_o       = 1'b0;
    req_ready_o     = 1'b0;
    scrmbl_valid_o  = 1'b0;
    scrmbl_cmd_o    = kdi_pkg::LoadShadow;
    entropy_sel_o   = 1'b0;
    seed_cnt_en     = 1'b0;
    seed_cnt_clr    = 1'b0;
    entropy_cnt_en  = 1'b0;
    entropy_cnt_clr = 1'b0;
    key_we_o        = 1'b0;
    nonce_we_o      = 1'b0;
    seed_valid_we_o = 1'b0;
    // Open request stays up until acked, also in ErrorSt
    edn_req_d       = edn_req_q & ~edn_ack_i;

    case (state_q)
      // Hold off until the OTP partitions are ready
      kdi_pkg::ResetSt: begin
        if (kdi_en_i) begin
          state_d = kdi_pkg::IdleSt;
        end
      end
      kdi_pkg::IdleSt: begin
        if (req_valid_i) begin
          state_d         = kdi_pkg::DigClrSt;
          seed_cnt_clr    = 1'b1;
          entropy_cnt_clr = 1'b1;
        end
      end
      // Revert digest to its IV
      kdi_pkg::DigClrSt: begin
        scrmbl_valid_o = 1'b1;
        scrmbl_cmd_o   = kdi_pkg::DigestInit;
        if (scrmbl_ready_i) begin
          state_d = kdi_pkg::DigLoadSt;
        end
      end
      // Two seed blocks, the second one starts a digest round
      kdi_pkg::DigLoadSt: begin
        scrmbl_valid_o = 1'b1;
        if (seed_cnt_q[0]) begin
          scrmbl_cmd_o = kdi_pkg::Digest;
          if (scrmbl_ready_i) begin
            state_d = ingest_entropy_i ? kdi_pkg::FetchEntropySt : kdi_pkg::DigFinSt;
          end
        end else if (scrmbl_ready_i) begin
          seed_cnt_en = 1'b1;
        end
      end
      // Two entropy words, parked in the nonce register
      kdi_pkg::FetchEntropySt: begin
        edn_req_d = ~edn_ack_i;
        if (edn_done) begin
          nonce_we_o = 1'b1;
          if (entropy_cnt_q == 2'd1) begin
            state_d         = kdi_pkg::DigEntropySt;
            entropy_cnt_clr = 1'b1;
          end else begin
            entropy_cnt_en = 1'b1;
          end
        end
      end
      kdi_pkg::DigEntropySt: begin
        scrmbl_valid_o = 1'b1;
        entropy_sel_o  = 1'b1;
        if (entropy_cnt_q[0]) begin
          scrmbl_cmd_o = kdi_pkg::Digest;
          if (scrmbl_ready_i) begin
            state_d         = kdi_pkg::DigFinSt;
            entropy_cnt_clr = 1'b1;
          end
        end else if (scrmbl_ready_i) begin
          entropy_cnt_en = 1'b1;
        end
      end
      kdi_pkg::DigFinSt: begin
        scrmbl_valid_o = 1'b1;
        scrmbl_cmd_o   = kdi_pkg::DigestFinalize;
        if (scrmbl_ready_i) begin
          state_d = kdi_pkg::DigWaitSt;
        end
      end
      // Result is one key half
      kdi_pkg::DigWaitSt: begin
        if (scrmbl_valid_i) begin
          key_we_o = 1'b1;
          if (seed_cnt_q == 2'd1) begin
            // Second half of the seed still to go
            seed_cnt_en = 1'b1;
            state_d     = kdi_pkg::DigClrSt;
          end else begin
            seed_cnt_clr    = 1'b1;
            seed_valid_we_o = 1'b1;
            state_d         = kdi_pkg::FetchNonceSt;
          end
        end
      end
      kdi_pkg::FetchNonceSt: begin
        edn_req_d = ~edn_ack_i;
        if (edn_done) begin
          nonce_we_o = 1'b1;
          if (entropy_cnt_q == nonce_last_i) begin
            state_d         = kdi_pkg::FinishSt;
            entropy_cnt_clr = 1'b1;
          end else begin
            entropy_cnt_en = 1'b1;
          end
        end
      end
      // Ack goes out in this cycle
      kdi_pkg::FinishSt: begin
        req_ready_o = 1'b1;
        state_d     = kdi_pkg::IdleSt;
      end
      // Terminal
      kdi_pkg::ErrorSt: begin
        fsm_err_o = 1'b1;
      end
      default: begin
        state_d   = kdi_pkg::ErrorSt;
        fsm_err_o = 1'b1;
      end
    endcase

    // Escalation overrides everything, nothing more leaves the unit
    if (escalate_i) begin
      state_d        = kdi_pkg::ErrorSt;
      fsm_err_o      = 1'b1;
      req_ready_o    = 1'b0;
      scrmbl_valid_o = 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= kdi_pkg::ResetSt;
      seed_cnt_q    <= '0;
      entropy_cnt_q <= '0;
      edn_req_q     <= 1'b0;
    end else begin
      state_q   <= state_d;
      edn_req_q <= edn_req_d;
      if (seed_cnt_clr) begin
        seed_cnt_q <= '0;
      end else if (seed_cnt_en) begin
        seed_cnt_q <= seed_cnt_q + 2'd1;
      end
      if (entropy_cnt_clr) begin
        entropy_cnt_q <= '0;
      end else if (entropy_cnt_en) begin
        entropy_cnt_q <= entropy_cnt_q + 2'd1;
      end
    end
  end

endmodule

//--- design/kdi_key_regs.sv
`timescale 1ns/1ps

module kdi_key_regs (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Current request
  input  kdi_pkg::seed_t       seed_i,
  input  logic                 seed_valid_i,
  // Control from the FSM
  input  logic                 entropy_sel_i,
  input  kdi_pkg::chunk_cnt_t  seed_cnt_i,
  input  kdi_pkg::chunk_cnt_t  entropy_cnt_i,
  input  logic                 key_we_i,
  input  logic                 nonce_we_i,
  input  logic                 seed_valid_we_i,
  // Data in
  input  kdi_pkg::block_t      scrmbl_data_i,
  input  kdi_pkg::block_t      edn_data_i,
  // Data out
  output kdi_pkg::block_t      scrmbl_data_o,
  output kdi_pkg::key_t        key_o,
  output kdi_pkg::nonce_t      nonce_o,
  output logic                 key_seed_valid_o
);

  kdi_pkg::key_t   key_q;
  kdi_pkg::nonce_t nonce_q;
  logic            seed_valid_q;

  // Bit offsets of the addressed slots
  int unsigned key_base;
  int unsigned nonce_base;
  int unsigned seed_base;

  // Low key half first, then high half
  assign key_base   = int'(seed_cnt_i[1]) * kdi_pkg::BlockWidth;
  assign nonce_base = int'(entropy_cnt_i[0]) * kdi_pkg::EdnWidth;
  assign seed_base  = int'(seed_cnt_i) * kdi_pkg::BlockWidth;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_q        <= '0;
      nonce_q      <= '0;
      seed_valid_q <= 1'b0;
    end else begin
      if (key_we_i) begin
        key_q[key_base +: kdi_pkg::BlockWidth] <= scrmbl_data_i;
      end
      if (nonce_we_i) begin
        nonce_q[nonce_base +: kdi_pkg::EdnWidth] <= edn_data_i;
      end
      if (seed_valid_we_i) begin
        seed_valid_q <= seed_valid_i;
      end
    end
  end

  // Entropy blocks come back out of the nonce register
  // Invalid seeds are gated to zero
  always_comb begin
    if (entropy_sel_i) begin
      scrmbl_data_o = nonce_q[nonce_base +: kdi_pkg::EdnWidth];
    end else if (seed_valid_i) begin
      scrmbl_data_o = seed_i[seed_base +: kdi_pkg::BlockWidth];
    end else begin
      scrmbl_data_o = '0;
    end
  end

  assign key_o            = key_q;
  assign nonce_o          = nonce_q;
  assign key_seed_valid_o = seed_valid_q;

endmodule

//--- design/kdi_top.sv
`timescale 1ns/1ps

module kdi_top (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        kdi_en_i,
  input  logic                        escalate_i,
  output logic                        fsm_err_o,
  // Key requesters
  input  logic [kdi_pkg::NumReq-1:0]  key_req_i,
  output logic [kdi_pkg::NumReq-1:0]  key_ack_o,
  output kdi_pkg::key_t               key_o,
  output kdi_pkg::nonce_t             nonce_o,
  output logic                        key_seed_valid_o,
  // Seeds
  input  kdi_pkg::seed_t              flash_data_seed_i,
  input  kdi_pkg::seed_t              flash_addr_seed_i,
  input  kdi_pkg::key_t               sram_seed_i,
  input  logic                        seed_valid_i,
  // Entropy source
  output logic                        edn_req_o,
  input  logic                        edn_ack_i,
  input  kdi_pkg::block_t             edn_data_i,
  // Digest engine
  output logic                        scrmbl_valid_o,
  output kdi_pkg::scrmbl_cmd_e        scrmbl_cmd_o,
  output kdi_pkg::digest_sel_e        scrmbl_sel_o,
  output kdi_pkg::block_t             scrmbl_data_o,
  input  logic                        scrmbl_ready_i,
  input  logic                        scrmbl_valid_i,
  input  kdi_pkg::block_t             scrmbl_data_i
);

  //////////////////////////////////////////////////////////////////////
  // Arbiter to FSM bundle
  //////////////////////////////////////////////////////////////////////

  logic                 req_valid;
  logic                 req_ready;
  logic                 ingest_entropy;
  kdi_pkg::digest_sel_e digest_sel;
  kdi_pkg::chunk_cnt_t  nonce_last;
  kdi_pkg::seed_t       seed;
  logic                 seed_valid;

  // FSM to datapath
  logic                 entropy_sel;
  kdi_pkg::chunk_cnt_t  seed_cnt;
  kdi_pkg::chunk_cnt_t  entropy_cnt;
  logic                 key_we;
  logic                 nonce_we;
  logic                 seed_valid_we;

  kdi_req_arbiter u_req_arbiter (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .key_req_i         (key_req_i),
    .key_ack_o         (key_ack_o),
    .flash_data_seed_i (flash_data_seed_i),
    .flash_addr_seed_i (flash_addr_seed_i),
    .sram_seed_i       (sram_seed_i),
    .seed_valid_i      (seed_valid_i),
    .req_valid_o       (req_valid),
    .req_ready_i       (req_ready),
    .ingest_entropy_o  (ingest_entropy),
    .digest_sel_o      (digest_sel),
    .nonce_last_o      (nonce_last),
    .seed_o            (seed),
    .seed_valid_o      (seed_valid)
  );

  kdi_ctrl_fsm u_ctrl_fsm (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .kdi_en_i         (kdi_en_i),
    .escalate_i       (escalate_i),
    .req_valid_i      (req_valid),
    .req_ready_o      (req_ready),
    .ingest_entropy_i (ingest_entropy),
    .digest_sel_i     (digest_sel),
    .nonce_last_i     (nonce_last),
    .fsm_err_o        (fsm_err_o),
    .scrmbl_valid_o   (scrmbl_valid_o),
    .scrmbl_cmd_o     (scrmbl_cmd_o),
    .scrmbl_sel_o     (scrmbl_sel_o),
    .scrmbl_ready_i   (scrmbl_ready_i),
    .scrmbl_valid_i   (scrmbl_valid_i),
    .edn_req_o        (edn_req_o),
    .edn_ack_i        (edn_ack_i),
    .entropy_sel_o    (entropy_sel),
    .seed_cnt_o       (seed_cnt),
    .entropy_cnt_o    (entropy_cnt),
    .key_we_o         (key_we),
    .nonce_we_o       (nonce_we),
    .seed_valid_we_o  (seed_valid_we)
  );

  kdi_key_regs u_key_regs (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .seed_i           (seed),
    .seed_valid_i     (seed_valid),
    .entropy_sel_i    (entropy_sel),
    .seed_cnt_i       (seed_cnt),
    .entropy_cnt_i    (entropy_cnt),
    .key_we_i         (key_we),
    .nonce_we_i       (nonce_we),
    .seed_valid_we_i  (seed_valid_we),
    .scrmbl_data_i    (scrmbl_data_i),
    .edn_data_i       (edn_data_i),
    .scrmbl_data_o    (scrmbl_data_o),
    .key_o            (key_o),
    .nonce_o          (nonce_o),
    .key_seed_valid_o (key_seed_valid_o)
  );

endmodule

//--- testbench/kdi_tests.svh
`ifndef KDI_TESTS_SVH
`define KDI_TESTS_SVH

  //////////////////////////////////////////////////////////////////////
  // Request handling
  //////////////////////////////////////////////////////////////////////

  // Reset held for two cycles, expected state cleared with it
  task automatic apply_reset();
    rst_ni     = 1'b0;
    kdi_en_i   = 1'b0;
    escalate_i = 1'b0;
    key_req_i  = '0;
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni    = 1'b1;
    exp_nonce = '0;
    edn_rd    = edn_wr_cnt;
  endtask

  task automatic pulse_enable();
    drive_point();
    kdi_en_i = 1'b1;
    drive_point();
    kdi_en_i = 1'b0;
  endtask

  task automatic raise_request(input int idx);
    drive_point();
    key_req_i = key_req_i | req_bit(idx);
  endtask

  task automatic drop_request(input int idx);
    drive_point();
    key_req_i = key_req_i & ~req_bit(idx);
  endtask

  // Returns at the falling edge of the ack cycle
  task automatic expect_ack(input int idx);
    int cycles;
    cycles = 0;
    sample_point();
    while (key_ack_o == '0) begin
      cycles++;
      if (cycles > Timeout) begin
        abort_run("no key ack before timeout");
      end
      sample_point();
    end
    check_eq("ack vector", 256'(req_bit(idx)), 256'(key_ack_o));
  endtask

  // Nothing may leave the unit during the window
  task automatic watch_quiet(input int cycles, input logic err_exp);
    for (int c = 0; c < cycles; c++) begin
      sample_point();
      check_eq("ack", 256'(0), 256'(key_ack_o));
      check_eq("scramble valid", 256'(0), 256'(scrmbl_valid_o));
      check_eq("fsm error", 256'(err_exp), 256'(fsm_err_o));
      if (!err_exp) begin
        check_eq("entropy request", 256'(0), 256'(edn_req_o));
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Expected results
  //////////////////////////////////////////////////////////////////////

  // Each key half is its own digest over two seed blocks plus optional entropy
  function automatic kdi_pkg::key_t model_key(input kdi_pkg::seed_t seed, input logic valid,
                                             input logic [1:0] sel, input logic ingest,
                                             input logic [255:0] ent);
    kdi_pkg::key_t   key;
    kdi_pkg::block_t acc;
    for (int h = 0; h < 2; h++) begin
      acc = '0;
      for (int b = 0; b < 2; b++) begin
        acc = {acc[62:0], acc[63]} ^ (valid ? seed[(2*h+b)*64 +: 64] : 64'd0);
      end
      if (ingest) begin
        for (int b = 0; b < 2; b++) begin
          acc = {acc[62:0], acc[63]} ^ ent[(2*h+b)*64 +: 64];
        end
      end
      key[h*64 +: 64] = acc ^ {32{sel}};
    end
    return key;
  endfunction

  task automatic pop_edn_word(output kdi_pkg::block_t word);
    if (edn_rd == edn_wr_cnt) begin
      abort_run("entropy word missing for the request");
    end
    word   = edn_words[6'(edn_rd)];
    edn_rd = edn_rd + 1;
  endtask

  // Called in the ack cycle, consumes this request's entropy words
  task automatic verify_result(input int idx);
    kdi_pkg::seed_t       seed;
    kdi_pkg::digest_sel_e sel;
    kdi_pkg::block_t      word;
    logic [255:0]         ent;
    logic                 ingest;
    int                   last;
    ent    = '0;
    ingest = (idx >= 2);
    seed   = (idx == 0) ? flash_data_seed_i :
             (idx == 1) ? flash_addr_seed_i : {sram_seed_i, sram_seed_i};
    sel    = (idx == 0) ? kdi_pkg::FlashDataKey :
             (idx == 1) ? kdi_pkg::FlashAddrKey : kdi_pkg::SramDataKey;
    last   = (idx == 0 || idx == 2) ? 1 : 0;
    // Entropy pairs pass through nonce chunks 0 and 1
    if (ingest) begin
      for (int w = 0; w < 4; w++) begin
        pop_edn_word(word);
        ent[w*64 +: 64]           = word;
        exp_nonce[(w%2)*64 +: 64] = word;
      end
    end
    check_eq("key", 256'(model_key(seed, seed_valid_i, sel, ingest, ent)), 256'(key_o));
    for (int c = 0; c <= last; c++) begin
      pop_edn_word(word);
      exp_nonce[c*64 +: 64] = word;
    end
    check_eq("nonce", 256'(exp_nonce), 256'(nonce_o));
    check_eq("seed valid", 256'(seed_valid_i), 256'(key_seed_valid_o));
    check_eq("extra entropy words", 256'(0), 256'(edn_wr_cnt - edn_rd));
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic reset_and_enable();
    test_name = "reset_and_enable";
    apply_reset();
    raise_request(0);
    // Not served while the FSM waits for enable
    watch_quiet(QuietCycles, 1'b0);
    pulse_enable();
    expect_ack(0);
    verify_result(0);
    drop_request(0);
  endtask

  task automatic flash_data_key();
    test_name = "flash_data_key";
    bp_en     = 1'b0;
    raise_request(0);
    expect_ack(0);
    verify_result(0);
    drop_request(0);
  endtask

  // Zero blocks into the digest, nonce chunk 1 left alone
  task automatic invalid_seed_gating();
    test_name = "invalid_seed_gating";
    bp_en     = 1'b0;
    drive_point();
    seed_valid_i = 1'b0;
    raise_request(1);
    expect_ack(1);
    verify_result(1);
    drop_request(1);
    seed_valid_i = 1'b1;
  endtask

  task automatic entropy_ingestion();
    test_name = "entropy_ingestion";
    bp_en     = 1'b1;
    raise_request(2);
    expect_ack(2);
    verify_result(2);
    drop_request(2);
  endtask

  // Pointer restarts at flash data after reset
  task automatic round_robin_order();
    test_name = "round_robin_order";
    bp_en     = 1'b1;
    apply_reset();
    pulse_enable();
    drive_point();
    key_req_i = '1;
    for (int k = 0; k < kdi_pkg::NumReq; k++) begin
      expect_ack(k);
      verify_result(k);
      drop_request(k);
    end
    watch_quiet(QuietCycles, 1'b0);
  endtask

  // Escalate while the OTBN request fetches entropy
  task automatic escalation_lockout();
    int cycles;
    test_name = "escalation_lockout";
    bp_en     = 1'b1;
    cycles    = 0;
    raise_request(3);
    sample_point();
    while (!edn_req_o) begin
      cycles++;
      if (cycles > Timeout) begin
        abort_run("OTBN request never reached the entropy fetch");
      end
      sample_point();
    end
    drive_point();
    escalate_i = 1'b1;
    drive_point();
    escalate_i = 1'b0;
    // Error must be held by the state register once escalation is gone
    sample_point();
    check_eq("fsm error on escalation", 256'(1), 256'(fsm_err_o));
    watch_quiet(QuietCycles, 1'b1);
  endtask

`endif

//--- testbench/kdi_tb.sv
`timescale 1ns/1ps

module kdi_tb;

  // Cycle limit for every wait loop
  localparam int Timeout     = 400;
  // Length of an observation window with no expected activity
  localparam int QuietCycles = 60;
  localparam int RngSeed     = 32'hacd10634;

  logic                       clk_i;
  logic                       rst_ni;
  logic                       kdi_en_i;
  logic                       escalate_i;
  logic                       fsm_err_o;
  logic [kdi_pkg::NumReq-1:0] key_req_i;
  logic [kdi_pkg::NumReq-1:0] key_ack_o;
  kdi_pkg::key_t              key_o;
  kdi_pkg::nonce_t            nonce_o;
  logic                       key_seed_valid_o;
  kdi_pkg::seed_t             flash_data_seed_i;
  kdi_pkg::seed_t             flash_addr_seed_i;
  kdi_pkg::key_t              sram_seed_i;
  logic                       seed_valid_i;
  logic                       edn_req_o;
  logic                       edn_ack_i;
  kdi_pkg::block_t            edn_data_i;
  logic                       scrmbl_valid_o;
  kdi_pkg::scrmbl_cmd_e       scrmbl_cmd_o;
  kdi_pkg::digest_sel_e       scrmbl_sel_o;
  kdi_pkg::block_t            scrmbl_data_o;
  logic                       scrmbl_ready_i;
  logic                       scrmbl_valid_i;
  kdi_pkg::block_t            scrmbl_data_i;

  // Random digest back-pressure on/off
  logic            bp_en;
  // Every word handed out by the entropy model, in order
  kdi_pkg::block_t edn_words [64];
  int              edn_wr_cnt;
  int              edn_rd;
  // Expected content of the nonce register
  kdi_pkg::nonce_t exp_nonce;
  string           test_name;

  kdi_top u_dut (.*);

  initial begin : clock_gen
    clk_i = 1'b0;
    forever begin
      #4 clk_i = ~clk_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Digest engine model
  //////////////////////////////////////////////////////////////////////

  // Accumulator rotates left by one and folds in each block
  // Transfers are sampled at the falling edge, responses driven after the rising edge
  initial begin : digest_model
    int                   rng;
    int                   res_wait;
    int                   draw;
    logic                 fire;
    logic [1:0]           sel;
    kdi_pkg::scrmbl_cmd_e cmd;
    kdi_pkg::block_t      data;
    kdi_pkg::block_t      acc;
    kdi_pkg::block_t      res;
    rng            = RngSeed;
    res_wait       = 0;
    acc            = '0;
    res            = '0;
    scrmbl_ready_i = 1'b1;
    scrmbl_valid_i = 1'b0;
    scrmbl_data_i  = '0;
    forever begin
      @(negedge clk_i);
      fire = scrmbl_valid_o & scrmbl_ready_i;
      cmd  = scrmbl_cmd_o;
      sel  = scrmbl_sel_o;
      data = scrmbl_data_o;
      @(posedge clk_i);
      #1;
      scrmbl_valid_i = 1'b0;
      // Pending result, one cycle pulse
      if (res_wait > 0) begin
        res_wait = res_wait - 1;
        if (res_wait == 0) begin
          scrmbl_valid_i = 1'b1;
          scrmbl_data_i  = res;
        end
      end
      if (fire) begin
        case (cmd)
          kdi_pkg::DigestInit: acc = '0;
          kdi_pkg::DigestFinalize: begin
            res      = acc ^ {32{sel}};
            res_wait = 1 + ($random(rng) & 3);
          end
          default: acc = {acc[62:0], acc[63]} ^ data;
        endcase
      end
      draw           = $random(rng);
      scrmbl_ready_i = bp_en ? draw[0] : 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Entropy source model
  //////////////////////////////////////////////////////////////////////

  initial begin : entropy_model
    int   rng;
    int   wait_cnt;
    logic busy;
    logic req;
    rng        = RngSeed;
    wait_cnt   = 0;
    busy       = 1'b0;
    edn_wr_cnt = 0;
    edn_ack_i  = 1'b0;
    edn_data_i = '0;
    forever begin
      @(negedge clk_i);
      req = edn_req_o;
      @(posedge clk_i);
      #1;
      if (edn_ack_i) begin
        // Word taken at this edge
        edn_ack_i = 1'b0;
        busy      = 1'b0;
      end else if (busy || req) begin
        if (!busy) begin
          busy     = 1'b1;
          wait_cnt = $random(rng) & 3;
        end
        if (wait_cnt == 0) begin
          edn_data_i                 = {$random(rng), $random(rng)};
          edn_words[6'(edn_wr_cnt)] = edn_data_i;
          edn_wr_cnt                 = edn_wr_cnt + 1;
          edn_ack_i                  = 1'b1;
        end else begin
          wait_cnt = wait_cnt - 1;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Common tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_eq(input string what, input logic [255:0] exp_val,
                          input logic [255:0] act_val);
    if (exp_val !== act_val) begin
      $display("[FAIL] %s %s expected %h actual %h", test_name, what, exp_val, act_val);
      $display("Test failed");
      $fatal(1, "Mismatch on %s", what);
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s: %s", test_name, why);
    $display("Test failed");
    $fatal(1, "%s", why);
  endtask

  // Inputs change 1 ns after the rising edge
  task automatic drive_point();
    @(posedge clk_i);
    #1;
  endtask

  // Outputs are stable at the falling edge
  task automatic sample_point();
    @(negedge clk_i);
  endtask

  function automatic logic [kdi_pkg::NumReq-1:0] req_bit(input int idx);
    return 4'b0001 << idx;
  endfunction

  `include "kdi_tests.svh"

  initial begin : main
    int seed_rng;
    seed_rng     = RngSeed;
    rst_ni       = 1'b0;
    kdi_en_i     = 1'b0;
    escalate_i   = 1'b0;
    key_req_i    = '0;
    seed_valid_i = 1'b1;
    bp_en        = 1'b0;
    edn_rd       = 0;
    exp_nonce    = '0;
    test_name    = "setup";
    for (int i = 0; i < 8; i++) begin
      flash_data_seed_i[i*32 +: 32] = $random(seed_rng);
      flash_addr_seed_i[i*32 +: 32] = $random(seed_rng);
    end
    for (int i = 0; i < 4; i++) begin
      sram_seed_i[i*32 +: 32] = $random(seed_rng);
    end
    reset_and_enable();
    flash_data_key();
    invalid_seed_gating();
    entropy_ingestion();
    round_robin_order();
    escalation_lockout();
    $display("Test passed");
    $finish;
  end

endmodule

//--- flist.f
+incdir+testbench
design/kdi_pkg.sv
design/kdi_req_arbiter.sv
design/kdi_ctrl_fsm.sv
design/kdi_key_regs.sv
design/kdi_top.sv
testbench/kdi_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the key derivation testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module kdi_tb -Mdir obj_dir -o kdi_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/kdi_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

echo "Simulation finished without errors"
exit 0
